// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mipsCoreTb
FILELIST = compile.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD)

// File: common/ctrlPkg.sv
// MIPS control definitions: ALU operation class, ALU function and the decoded control word
`default_nettype none

package ctrlPkg;

  // ==========================================================================
  // ALU selection
  // ==========================================================================

  // operation class from main control
  // opAdd for lw/sw address, opSub for beq compare, opFunct from funct field
  typedef enum logic [1:0] {
    opAdd,
    opSub,
    opFunct
  } aluOpClass;

  // function the ALU carries out
  // aluBad marks an unknown R-type code
  typedef enum logic [2:0] {
    aluAnd,
    aluOr,
    aluAdd,
    aluSub,
    aluSlt,
    aluBad
  } aluFunc;

  // ==========================================================================
  // decoded control
  // ==========================================================================

  typedef struct packed {
    // destination from rd instead of rt
    logic      regDst;
    // second ALU operand is the immediate
    logic      aluSrc;
    // write back memory data
    logic      memToReg;
    logic      regWrite;
    logic      memWrite;
    // beq
    logic      branch;
    // j and jal
    logic      jump;
    // jal, link into ra
    logic      link;
    aluOpClass aluClass;
  } ctrlWord;

endpackage

`default_nettype wire

// File: common/isaPkg.sv
// MIPS instruction-set definitions: field types, opcodes, function codes, register numbers
`default_nettype none

package isaPkg;

  // ==========================================================================
  // field and value types
  // ==========================================================================

  // data word and byte address
  typedef logic [31:0] word;
  // register number
  typedef logic [4:0]  regAddr;
  // major opcode, instr[31:26]
  typedef logic [5:0]  opcode;
  // R-type function code, instr[5:0]
  typedef logic [5:0]  funct;
  // I-type immediate, instr[15:0]
  typedef logic [15:0] imm16;
  // J-type word index, instr[25:0]
  typedef logic [25:0] jumpTarget;

  // ==========================================================================
  // encodings
  // ==========================================================================

  // major opcodes of the supported subset
  localparam opcode opR   = 6'b000000;
  localparam opcode opJ   = 6'b000010;
  localparam opcode opJal = 6'b000011;
  localparam opcode opBeq = 6'b000100;
  localparam opcode opLw  = 6'b100011;
  localparam opcode opSw  = 6'b101011;

  // R-type function codes
  localparam funct fnAdd = 6'b100000;
  localparam funct fnSub = 6'b100010;
  localparam funct fnAnd = 6'b100100;
  localparam funct fnOr  = 6'b100101;
  localparam funct fnSlt = 6'b101010;

  // special registers
  // always reads zero, writes are lost
  localparam regAddr regZero = 5'd0;
  // jal return address
  localparam regAddr regRa   = 5'd31;

endpackage

`default_nettype wire

// File: compile.f
common/isaPkg.sv
common/ctrlPkg.sv
src/decoder.sv
src/alu.sv
src/regFile.sv
src/pcUnit.sv
src/mipsCore.sv
verification/tbClock.sv
verification/mipsCoreTb.sv

// File: src/alu.sv
// 32-bit MIPS ALU with and, or, add, sub, signed slt and a zero flag
`default_nettype none

module alu (
  input  isaPkg::word     a,
  input  isaPkg::word     b,
  input  ctrlPkg::aluFunc fn,
  output isaPkg::word     result,
  output logic            zero
);

  import ctrlPkg::*;

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (fn)
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      aluAdd: result = a + b;
      aluSub: result = a - b;
      // 1 or 0 in bit zero
      aluSlt: result = {31'd0, lessThan};
      // aluBad and anything unknown
      default: result = '0;
    endcase
  end

  // zero flag for any function
  // only pcUnit gives it meaning, under beq
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: src/decoder.sv
// MIPS main control and ALU control, opcode and function code to control word
`default_nettype none

module decoder (
  input  isaPkg::opcode    opcode,
  input  isaPkg::funct     funct,
  output ctrlPkg::ctrlWord ctrl,
  output ctrlPkg::aluFunc  aluFn
);

  import isaPkg::*;
  import ctrlPkg::*;

  always_comb begin
    // ========================================================================
    // main control
    // ========================================================================
    // unknown opcode falls out as a no-op, all enables low
    ctrl = '0;
    ctrl.aluClass = opAdd;
    case (opcode)
      opR: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluClass = opFunct;
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      opBeq: begin
        // compare by subtraction, zero flag decides
        ctrl.branch   = 1'b1;
        ctrl.aluClass = opSub;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      opJal: begin
        // return address goes to ra
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        ctrl.aluClass = opAdd;
      end
    endcase

    // ========================================================================
    // ALU control
    // ========================================================================
    case (ctrl.aluClass)
      opSub:   aluFn = aluSub;
      opFunct: begin
        case (funct)
          fnAdd:   aluFn = aluAdd;
          fnSub:   aluFn = aluSub;
          fnAnd:   aluFn = aluAnd;
          fnOr:    aluFn = aluOr;
          fnSlt:   aluFn = aluSlt;
          default: begin
            // unknown R-type, suppress the write
            aluFn = aluBad;
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      default: aluFn = aluAdd;
    endcase
  end

endmodule

`default_nettype wire

// File: src/mipsCore.sv
// single-cycle MIPS integer core with instruction and data memory ports
`default_nettype none

module mipsCore #(
  parameter int dataAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  output isaPkg::word              instrAddr,
  input  isaPkg::word              instr,
  output logic [dataAddrWidth-1:0] dataAddr,
  output isaPkg::word              dataWrite,
  output logic                     dataWe,
  input  isaPkg::word              dataRead,
  output isaPkg::word              wbData
);

  import isaPkg::*;
  import ctrlPkg::*;

  // instruction fields
  opcode     opField;
  funct      fnField;
  regAddr    rsField;
  regAddr    rtField;
  regAddr    rdField;
  imm16      immField;
  jumpTarget tgtField;

  ctrlWord ctrl;
  aluFunc  aluFn;
  word     immExt;
  word     rsData;
  word     rtData;
  word     aluB;
  word     aluResult;
  logic    aluZero;
  regAddr  wrAddr;
  word     linkAddr;

  // ==========================================================================
  // field split and immediate
  // ==========================================================================
  assign opField  = instr[31:26];
  assign rsField  = instr[25:21];
  assign rtField  = instr[20:16];
  assign rdField  = instr[15:11];
  assign fnField  = instr[5:0];
  assign immField = instr[15:0];
  assign tgtField = instr[25:0];
  assign immExt   = {{16{immField[15]}}, immField};

  decoder decoder_i (.opcode(opField), .funct(fnField), .ctrl(ctrl), .aluFn(aluFn));

  regFile regFile_i (
    .clk(clk), .rst(rst), .we(ctrl.regWrite),
    .rdAddrA(rsField), .rdAddrB(rtField), .wrAddr(wrAddr), .wrData(wbData),
    .rdDataA(rsData), .rdDataB(rtData)
  );

  // ==========================================================================
  // selectors
  // ==========================================================================
  // immediate for lw and sw, rt otherwise
  assign aluB = ctrl.aluSrc ? immExt : rtData;

  // jal links into ra, R-type to rd, loads to rt
  assign wrAddr = ctrl.link ? regRa : (ctrl.regDst ? rdField : rtField);

  // write-back value
  assign wbData = ctrl.link ? linkAddr : (ctrl.memToReg ? dataRead : aluResult);

  alu alu_i (.a(rsData), .b(aluB), .fn(aluFn), .result(aluResult), .zero(aluZero));

  pcUnit pcUnit_i (
    .clk(clk), .rst(rst), .ctrl(ctrl), .imm(immExt), .target(tgtField),
    .aluZero(aluZero), .pc(instrAddr), .linkAddr(linkAddr)
  );

  // ==========================================================================
  // data memory port
  // ==========================================================================
  // byte address to word address
  assign dataAddr  = aluResult[dataAddrWidth+1:2];
  assign dataWrite = rtData;
  assign dataWe    = ctrl.memWrite;

endmodule

`default_nettype wire

// File: src/pcUnit.sv
// MIPS program counter with sequential, branch and jump next-address selection
`default_nettype none

module pcUnit (
  input  logic              clk,
  input  logic              rst,
  input  ctrlPkg::ctrlWord  ctrl,
  input  isaPkg::word       imm,
  input  isaPkg::jumpTarget target,
  input  logic              aluZero,
  output isaPkg::word       pc,
  output isaPkg::word       linkAddr
);

  import isaPkg::*;

  word pcPlus4;
  word branchAddr;
  word jumpAddr;
  word pcNext;

  // ==========================================================================
  // candidate addresses
  // ==========================================================================
  assign pcPlus4    = pc + 32'd4;
  // word offset, relative to the delay-free next instruction
  assign branchAddr = pcPlus4 + {imm[29:0], 2'b00};
  // region bits kept from pc+4
  assign jumpAddr   = {pcPlus4[31:28], target, 2'b00};
  // jal return address
  assign linkAddr   = pc + 32'd8;

  // jump first, then taken branch, else sequential
  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpAddr;
    end else if (ctrl.branch && aluZero) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // every path keeps the pc on a word boundary
  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/regFile.sv
// MIPS register file, 32 entries, two combinational reads, one registered write
`default_nettype none

module regFile (
  input  logic           clk,
  input  logic           rst,
  input  logic           we,
  input  isaPkg::regAddr rdAddrA,
  input  isaPkg::regAddr rdAddrB,
  input  isaPkg::regAddr wrAddr,
  input  isaPkg::word    wrData,
  output isaPkg::word    rdDataA,
  output isaPkg::word    rdDataB
);

  import isaPkg::*;

  // no storage behind register zero
  word regs [31:1];

  // ==========================================================================
  // write port
  // ==========================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wrAddr != regZero)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ==========================================================================
  // read ports
  // ==========================================================================
  // register zero reads as constant zero
  assign rdDataA = (rdAddrA == regZero) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == regZero) ? '0 : regs[rdAddrB];

  // a fresh write shows up on the next read of the same register
  readBackA: assert property (@(posedge clk) disable iff (!rst)
    (we && (wrAddr != regZero)) |=>
      ((rdAddrA != $past(wrAddr)) || (rdDataA == $past(wrData))));

  readBackB: assert property (@(posedge clk) disable iff (!rst)
    (we && (wrAddr != regZero)) |=>
      ((rdAddrB != $past(wrAddr)) || (rdDataB == $past(wrData))));

endmodule

`default_nettype wire

// File: verification/mipsCoreTb.sv
// testbench for the single-cycle MIPS core: memory models and directed instruction tests
`default_nettype none

module mipsCoreTb;

  import isaPkg::*;

  localparam int dataAddrWidth = 7;
  // instructions stepped over all tests
  localparam int totalSteps    = 29;
  // six test resets plus power-up
  localparam int resetCount    = 7;
  localparam int cycleLimit    = totalSteps * 2 + resetCount * 10;

  logic                     clk;
  logic                     rst;
  logic                     resetReq;
  word                      instrAddr;
  word                      instr;
  logic [dataAddrWidth-1:0] dataAddr;
  word                      dataWrite;
  logic                     dataWe;
  word                      dataRead;
  word                      wbData;

  word         imem [0:63];
  word         dmem [0:127];
  logic [31:0] lfsrState;
  int          cycleCount = 0;

  tbClock #(.period(20), .resetCycles(5)) tbClock_i (
    .resetReq(resetReq), .clk(clk), .rst(rst)
  );

  mipsCore #(.dataAddrWidth(dataAddrWidth)) mipsCore_i (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWrite(dataWrite), .dataWe(dataWe),
    .dataRead(dataRead), .wbData(wbData)
  );

  // ==========================================================================
  // memory models
  // ==========================================================================
  // fetch by word index, nop while in reset
  assign instr    = rst ? imem[instrAddr[7:2]] : '0;
  assign dataRead = dmem[dataAddr];

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // ==========================================================================
  // encoding and stimulus helpers
  // ==========================================================================
  function automatic word encR(input regAddr rs, input regAddr rt, input regAddr rd,
                               input funct fn);
    return {opR, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word encI(input opcode op, input regAddr rs, input regAddr rt,
                               input imm16 imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word encJ(input opcode op, input jumpTarget target);
    return {op, target};
  endfunction

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsrBit();
    logic feedback;
    feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], feedback};
    return feedback;
  endfunction

  function automatic word randWord();
    word value;
    for (int i = 0; i < 32; i++) begin
      value = {value[30:0], lfsrBit()};
    end
    return value;
  endfunction

  task automatic checkValue(input string testName, input word expected, input word actual);
    if (actual !== expected) begin
      $display("error: %s expected %h actual %h", testName, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // program of nops, data filled from the word address
  task automatic clearMemories();
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < 128; i++) begin
      dmem[i] = 32'hda7a0000 + i;
    end
  endtask

  task automatic resetCore();
    resetReq = 1'b1;
    wait (rst == 1'b0);
    resetReq = 1'b0;
    wait (rst == 1'b1);
  endtask

  task automatic stepCycle();
    @(posedge clk);
    // store lands on the same edge as the register write
    if (dataWe) begin
      dmem[dataAddr] = dataWrite;
    end
    #1;
  endtask

  // check one instruction before its closing edge, then run it
  task automatic execute(input string testName, input word expPc, input bit hasWb,
                         input word expWb);
    checkValue({testName, " pc"}, expPc, instrAddr);
    if (hasWb) begin
      checkValue({testName, " wb"}, expWb, wbData);
    end
    stepCycle();
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic arithTest();
    word a;
    word b;
    a = randWord();
    b = randWord();
    clearMemories();
    dmem[4] = a;
    dmem[5] = b;
    imem[0] = encI(opLw, 5'd0, 5'd1, 16'd16);
    imem[1] = encI(opLw, 5'd0, 5'd2, 16'd20);
    imem[2] = encR(5'd1, 5'd2, 5'd3, fnAdd);
    imem[3] = encR(5'd1, 5'd2, 5'd4, fnSub);
    imem[4] = encR(5'd1, 5'd2, 5'd5, fnAnd);
    imem[5] = encR(5'd1, 5'd2, 5'd6, fnOr);
    resetCore();
    execute("arith lw a", 32'd0, 1'b1, a);
    execute("arith lw b", 32'd4, 1'b1, b);
    execute("arith add", 32'd8, 1'b1, a + b);
    execute("arith sub", 32'd12, 1'b1, a - b);
    execute("arith and", 32'd16, 1'b1, a & b);
    execute("arith or", 32'd20, 1'b1, a | b);
  endtask

  task automatic sltTest();
    word neg;
    word pos;
    // sign bits forced so the signed order is known
    neg = randWord() | 32'h80000000;
    pos = randWord() & 32'h7fffffff;
    clearMemories();
    dmem[0] = neg;
    dmem[1] = pos;
    imem[0] = encI(opLw, 5'd0, 5'd1, 16'd0);
    imem[1] = encI(opLw, 5'd0, 5'd2, 16'd4);
    imem[2] = encR(5'd1, 5'd2, 5'd3, fnSlt);
    imem[3] = encR(5'd2, 5'd1, 5'd4, fnSlt);
    resetCore();
    execute("slt lw neg", 32'd0, 1'b1, neg);
    execute("slt lw pos", 32'd4, 1'b1, pos);
    execute("slt less", 32'd8, 1'b1, 32'd1);
    execute("slt greater", 32'd12, 1'b1, 32'd0);
  endtask

  task automatic storeLoadTest();
    word value;
    value = randWord();
    clearMemories();
    dmem[2] = value;
    // base 40 plus offset 24 is byte 64, word 16
    dmem[3] = 32'd40;
    imem[0] = encI(opLw, 5'd0, 5'd1, 16'd8);
    imem[1] = encI(opLw, 5'd0, 5'd2, 16'd12);
    imem[2] = encI(opSw, 5'd2, 5'd1, 16'd24);
    imem[3] = encI(opLw, 5'd2, 5'd3, 16'd24);
    resetCore();
    execute("store lw value", 32'd0, 1'b1, value);
    execute("store lw base", 32'd4, 1'b1, 32'd40);
    execute("store sw", 32'd8, 1'b0, '0);
    execute("store lw back", 32'd12, 1'b1, value);
    checkValue("store memory", value, dmem[16]);
  endtask

  task automatic branchTest();
    word w;
    w = randWord();
    clearMemories();
    dmem[0] = w;
    dmem[1] = w;
    dmem[2] = w ^ 32'h1;
    imem[0] = encI(opLw, 5'd0, 5'd1, 16'd0);
    imem[1] = encI(opLw, 5'd0, 5'd2, 16'd4);
    imem[2] = encI(opLw, 5'd0, 5'd3, 16'd8);
    // taken, 12 + 4 + 2 words
    imem[3] = encI(opBeq, 5'd1, 5'd2, 16'd2);
    // not taken
    imem[6] = encI(opBeq, 5'd1, 5'd3, 16'd3);
    resetCore();
    execute("branch lw r1", 32'd0, 1'b1, w);
    execute("branch lw r2", 32'd4, 1'b1, w);
    execute("branch lw r3", 32'd8, 1'b1, w ^ 32'h1);
    execute("branch beq equal", 32'd12, 1'b0, '0);
    execute("branch beq unequal", 32'd16 + (32'd2 << 2), 1'b0, '0);
    execute("branch fall through", 32'd28, 1'b0, '0);
  endtask

  task automatic jumpTest();
    clearMemories();
    imem[0]  = encJ(opJ, 26'd5);
    imem[5]  = encJ(opJal, 26'd10);
    imem[10] = encI(opSw, 5'd0, 5'd31, 16'd48);
    imem[11] = encI(opLw, 5'd0, 5'd5, 16'd48);
    resetCore();
    execute("jump j", 32'd0, 1'b0, '0);
    // link is own address plus 8
    execute("jump jal", 32'd20, 1'b1, 32'd28);
    execute("jump sw ra", 32'd40, 1'b0, '0);
    execute("jump lw ra", 32'd44, 1'b1, 32'd28);
    checkValue("jump link memory", 32'd28, dmem[12]);
  endtask

  task automatic zeroRegTest();
    word a;
    word b;
    a = randWord();
    b = randWord();
    clearMemories();
    dmem[0] = a;
    dmem[1] = b;
    imem[0] = encI(opLw, 5'd0, 5'd1, 16'd0);
    imem[1] = encI(opLw, 5'd0, 5'd2, 16'd4);
    imem[2] = encR(5'd1, 5'd2, 5'd0, fnAdd);
    imem[3] = encI(opSw, 5'd0, 5'd0, 16'd32);
    imem[4] = encI(opLw, 5'd0, 5'd3, 16'd32);
    resetCore();
    execute("zero lw a", 32'd0, 1'b1, a);
    execute("zero lw b", 32'd4, 1'b1, b);
    // sum shows on wbData but r0 keeps zero
    execute("zero add r0", 32'd8, 1'b1, a + b);
    execute("zero sw r0", 32'd12, 1'b0, '0);
    execute("zero lw back", 32'd16, 1'b1, 32'd0);
    checkValue("zero memory", 32'd0, dmem[8]);
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    resetReq  = 1'b0;
    lfsrState = 32'hb8bb;
    arithTest();
    sltTest();
    storeLoadTest();
    branchTest();
    jumpTest();
    zeroRegTest();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
// testbench clock and reset generator, reset held low for a set number of cycles
`default_nettype none

module tbClock #(
  parameter int period      = 20,
  parameter int resetCycles = 5
) (
  input  logic resetReq,
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2);
      clk = ~clk;
    end
  end

  // power-up reset, then one more for each request
  initial begin
    rst = 1'b0;
    forever begin
      repeat (resetCycles) @(posedge clk);
      // release just after the edge, like every other input
      #1;
      rst = 1'b1;
      @(posedge resetReq);
      rst = 1'b0;
    end
  end

endmodule

`default_nettype wire
